// File: logic/gamePkg.sv
/*
 * playfield types for the dragon arena
 * tile positions on the wrapping grid, travel direction, one-tile step
 */
package gamePkg;

    localparam int GridSize   = 16;                 // tiles per axis
    localparam int CoordWidth = $clog2(GridSize);   // bits per coordinate

    // one tile on the grid, wraps modulo GridSize
    typedef struct packed {
        logic [CoordWidth-1:0] x;
        logic [CoordWidth-1:0] y;
    } posT;

    typedef enum logic [1:0] {
        dirRight = 2'd0,
        dirLeft  = 2'd1,
        dirDown  = 2'd2,
        dirUp    = 2'd3
    } dirT;

    // move a position by one tile, the coordinate width gives the wrap for free
    function automatic posT stepPos(input posT pos, input dirT dir);
        posT next;
        next = pos;
        case (dir)
            dirRight: next.x = pos.x + 1'b1;
            dirLeft:  next.x = pos.x - 1'b1;
            dirDown:  next.y = pos.y + 1'b1;
            dirUp:    next.y = pos.y - 1'b1;
            default:  next = pos;
        endcase
        return next;
    endfunction

endpackage

// File: logic/collisionPkg.sv
/*
 * game event types
 * per-frame hit flags and the running score record
 */
package collisionPkg;

    localparam int LivesWidth   = 4;
    localparam int CounterWidth = 8;    // event counters saturate at all ones

    typedef struct packed {
        logic player;   // dragon touched the player
        logic sword;    // sword landed on the dragon
        logic sheep;    // dragon reached the sheep
    } hitsT;

    typedef struct packed {
        logic [LivesWidth-1:0]   lives;
        logic [CounterWidth-1:0] dragonWounds;
        logic [CounterWidth-1:0] sheepLost;
    } tallyT;

endpackage

// File: logic/frameTicker.sv
/*
 * frame ticker
 * counts clock cycles and emits a one-cycle frame start every FramePeriod
 */
module frameTicker #(
    parameter int FramePeriod = 64
) (
    input  logic clk,
    input  logic reset,
    output logic frameStart
);

    localparam int CountWidth = (FramePeriod > 1) ? $clog2(FramePeriod) : 1;

    logic [CountWidth-1:0] cycleCount;

    // first pulse lands FramePeriod cycles after reset goes away
    always_ff @(posedge clk) begin
        if (!reset) begin
            cycleCount <= '0;
            frameStart <= 1'b0;
        end else begin
            if (cycleCount == CountWidth'(FramePeriod - 1)) begin
                cycleCount <= '0;
                frameStart <= 1'b1;     // wrap point
            end else begin
                cycleCount <= cycleCount + 1'b1;
                frameStart <= 1'b0;
            end
        end
    end

endmodule

// File: logic/dragonMover.sv
/*
 * dragon mover
 * steps the head once per frame, body segments follow, grows on request
 */
module dragonMover #(
    parameter int           NumSegments = 7,
    parameter gamePkg::posT StartHead   = '{x: 4'd8, y: 4'd8}
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               frameStart,
    input  gamePkg::dirT                       dir,
    input  logic                               grow,
    output gamePkg::posT [NumSegments-1:0]     segments,
    output logic         [NumSegments-1:0]     activeMask
);

    logic growPending;  // grow seen between frames
    logic growNow;

    assign growNow = grow || growPending;

    // body is a shift register of tiles, index 0 is the head
    always_ff @(posedge clk) begin
        if (!reset) begin
            segments <= {NumSegments{StartHead}};  // whole body stacked on one tile
        end else if (frameStart) begin
            segments[0] <= gamePkg::stepPos(segments[0], dir);
            for (int k = 1; k < NumSegments; k++) begin
                segments[k] <= segments[k-1];      // each segment takes its leader's old tile
            end
        end
    end

    // active mask fills from the head end, so shifting a one in sets the lowest free bit
    always_ff @(posedge clk) begin
        if (!reset) begin
            activeMask <= {{(NumSegments-1){1'b0}}, 1'b1};
        end else if (frameStart && growNow) begin
            activeMask <= {activeMask[NumSegments-2:0], 1'b1};  // stays full once all set
        end
    end

    /* a grow request arriving mid-frame is held until the next frame start,
       one arriving on the frame start itself is used straight away */
    always_ff @(posedge clk) begin
        if (!reset) begin
            growPending <= 1'b0;
        end else if (frameStart) begin
            growPending <= 1'b0;
        end else if (grow) begin
            growPending <= 1'b1;
        end
    end

endmodule

// File: logic/collisionDetector.sv
/*
 * collision detector
 * walks the frozen dragon body one segment per cycle and sets sticky hit flags
 */
module collisionDetector #(
    parameter int NumSegments = 7
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               frameStart,
    input  gamePkg::posT [NumSegments-1:0]     segments,
    input  logic         [NumSegments-1:0]     activeMask,
    input  gamePkg::posT                       playerPos,
    input  gamePkg::posT                       swordPos,
    input  gamePkg::posT                       sheepPos,
    output collisionPkg::hitsT                 hits,
    output logic                               scanDone
);

    localparam int CountWidth = (NumSegments > 1) ? $clog2(NumSegments) : 1;

    // frame-start copy of everything the scan reads
    gamePkg::posT [NumSegments-1:0] snapSegments;
    logic         [NumSegments-1:0] snapMask;
    gamePkg::posT                   snapPlayer;
    gamePkg::posT                   snapSword;
    gamePkg::posT                   snapSheep;

    logic [CountWidth-1:0] segCount;
    logic                  scanning;
    logic                  lastSeg;
    gamePkg::posT          curSeg;
    logic                  curActive;

    assign curSeg    = snapSegments[segCount];
    assign curActive = snapMask[segCount];
    assign lastSeg   = (segCount == CountWidth'(NumSegments - 1));

    // snapshot, so a move or object change during the scan cannot tear the result
    always_ff @(posedge clk) begin
        if (frameStart) begin
            snapSegments <= segments;
            snapMask     <= activeMask;
            snapPlayer   <= playerPos;
            snapSword    <= swordPos;
            snapSheep    <= sheepPos;
        end
    end

    // scan sequencer, one segment per cycle after frame start
    always_ff @(posedge clk) begin
        if (!reset) begin
            segCount <= '0;
            scanning <= 1'b0;
            scanDone <= 1'b0;
        end else if (frameStart) begin
            segCount <= '0;
            scanning <= 1'b1;
            scanDone <= 1'b0;
        end else begin
            scanDone <= scanning && lastSeg;   // lands NumSegments+1 after frame start
            if (scanning) begin
                if (lastSeg) begin
                    scanning <= 1'b0;
                end else begin
                    segCount <= segCount + 1'b1;
                end
            end
        end
    end

    // sticky flags, cleared only by the next frame start
    always_ff @(posedge clk) begin
        if (!reset) begin
            hits <= '0;
        end else if (frameStart) begin
            hits <= '0;
        end else if (scanning && curActive) begin
            hits.player <= hits.player | (curSeg == snapPlayer);
            hits.sword  <= hits.sword  | (curSeg == snapSword);
            hits.sheep  <= hits.sheep  | (curSeg == snapSheep);
        end
    end

endmodule

// File: logic/gameTally.sv
/*
 * game tally
 * applies each frame's hits once to lives, dragon wounds and sheep lost
 */
module gameTally #(
    parameter int StartLives = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  collisionPkg::hitsT hits,
    input  logic               scanDone,
    output collisionPkg::tallyT tally,
    output logic               gameOver
);

    localparam int LivesWidth   = collisionPkg::LivesWidth;
    localparam int CounterWidth = collisionPkg::CounterWidth;
    localparam logic [CounterWidth-1:0] CounterMax = {CounterWidth{1'b1}};

    logic applyHits;

    assign gameOver  = (tally.lives == '0);          // level, follows lives
    assign applyHits = scanDone && !gameOver;        // tally frozen after game over

    always_ff @(posedge clk) begin
        if (!reset) begin
            tally.lives        <= LivesWidth'(StartLives);
            tally.dragonWounds <= '0;
            tally.sheepLost    <= '0;
        end else if (applyHits) begin
            // lives stop at zero
            if (hits.player && tally.lives != '0) begin
                tally.lives <= tally.lives - 1'b1;
            end
            // counters saturate
            if (hits.sword && tally.dragonWounds != CounterMax) begin
                tally.dragonWounds <= tally.dragonWounds + 1'b1;
            end
            if (hits.sheep && tally.sheepLost != CounterMax) begin
                tally.sheepLost <= tally.sheepLost + 1'b1;
            end
        end
    end

endmodule

// File: logic/dragonArena.sv
/*
 * dragon arena core
 * frame ticker, dragon mover, collision scan and score tally
 */
module dragonArena #(
    parameter int           NumSegments = 7,
    parameter int           FramePeriod = 64,  // must exceed NumSegments + 2
    parameter int           StartLives  = 3,
    parameter gamePkg::posT StartHead   = '{x: 4'd8, y: 4'd8}
) (
    input  logic                               clk,
    input  logic                               reset,
    input  gamePkg::dirT                       dir,
    input  logic                               grow,
    input  gamePkg::posT                       playerPos,
    input  gamePkg::posT                       swordPos,
    input  gamePkg::posT                       sheepPos,
    output collisionPkg::hitsT                 hits,
    output logic                               scanDone,
    output collisionPkg::tallyT                tally,
    output logic                               gameOver,
    output gamePkg::posT [NumSegments-1:0]     segments,
    output logic         [NumSegments-1:0]     activeMask
);

    logic frameStart;

    frameTicker #(
        .FramePeriod(FramePeriod)
    ) i_frameTicker (
        .clk       (clk),
        .reset     (reset),
        .frameStart(frameStart)
    );

    dragonMover #(
        .NumSegments(NumSegments),
        .StartHead  (StartHead)
    ) i_dragonMover (
        .clk       (clk),
        .reset     (reset),
        .frameStart(frameStart),
        .dir       (dir),
        .grow      (grow),
        .segments  (segments),
        .activeMask(activeMask)
    );

    // sees the pre-move body, it snapshots on the same edge the mover steps
    collisionDetector #(
        .NumSegments(NumSegments)
    ) i_collisionDetector (
        .clk       (clk),
        .reset     (reset),
        .frameStart(frameStart),
        .segments  (segments),
        .activeMask(activeMask),
        .playerPos (playerPos),
        .swordPos  (swordPos),
        .sheepPos  (sheepPos),
        .hits      (hits),
        .scanDone  (scanDone)
    );

    gameTally #(
        .StartLives(StartLives)
    ) i_gameTally (
        .clk     (clk),
        .reset   (reset),
        .hits    (hits),
        .scanDone(scanDone),
        .tally   (tally),
        .gameOver(gameOver)
    );

endmodule

// File: sim/clockGen.sv
/*
 * testbench clock and reset generator
 * free-running clock, active-low reset held for a few cycles
 */
module clockGen #(
    parameter int PeriodNs    = 20,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // released on a falling edge, like the other DUT inputs
    initial begin
        reset = 1'b0;
        repeat (ResetCycles) @(negedge clk);
        reset = 1'b1;
    end

endmodule

// File: sim/dragonArenaTb.sv
/*
 * dragon arena testbench
 * reference model of body, scan and tally, checked by concurrent assertions
 */
module dragonArenaTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int           NumSegments = 7;
    localparam int           FramePeriod = 16;
    localparam int           StartLives  = 3;
    localparam gamePkg::posT StartHead   = '{x: 4'd8, y: 4'd8};
    localparam int           WaitLimit   = 40;
    localparam int           Idle        = 100;   // no scan in flight

    logic                           clk;
    logic                           reset;
    gamePkg::dirT                   dir;
    logic                           grow;
    gamePkg::posT                   playerPos;
    gamePkg::posT                   swordPos;
    gamePkg::posT                   sheepPos;
    collisionPkg::hitsT             hits;
    logic                           scanDone;
    collisionPkg::tallyT            tally;
    logic                           gameOver;
    gamePkg::posT [NumSegments-1:0] segments;
    logic         [NumSegments-1:0] activeMask;

    // reference model state
    gamePkg::posT [NumSegments-1:0] mSeg;
    logic         [NumSegments-1:0] mMask;
    logic                           mGrowPend;
    logic                           mFrame;
    int                             tickCount;
    int                             sinceFrame;
    collisionPkg::hitsT             frameHits;
    collisionPkg::hitsT             mHitsVis;
    collisionPkg::tallyT            mTally;

    int seed = 73;
    int errorCount = 0;
    int timeoutCount = 0;
    bit aborted = 1'b0;

    clockGen #(
        .PeriodNs   (20),
        .ResetCycles(4)
    ) i_clockGen (
        .clk  (clk),
        .reset(reset)
    );

    dragonArena #(
        .NumSegments(NumSegments),
        .FramePeriod(FramePeriod),
        .StartLives (StartLives),
        .StartHead  (StartHead)
    ) i_dragonArena (
        .clk       (clk),
        .reset     (reset),
        .dir       (dir),
        .grow      (grow),
        .playerPos (playerPos),
        .swordPos  (swordPos),
        .sheepPos  (sheepPos),
        .hits      (hits),
        .scanDone  (scanDone),
        .tally     (tally),
        .gameOver  (gameOver),
        .segments  (segments),
        .activeMask(activeMask)
    );

    // one tile step, coordinates wrap modulo the grid size
    function automatic gamePkg::posT stepTile(input gamePkg::posT p, input gamePkg::dirT d);
        gamePkg::posT n;
        int x;
        int y;
        x = p.x;
        y = p.y;
        case (d)
            gamePkg::dirRight: x = x + 1;
            gamePkg::dirLeft:  x = x + gamePkg::GridSize - 1;
            gamePkg::dirDown:  y = y + 1;
            default:           y = y + gamePkg::GridSize - 1;
        endcase
        n.x = 4'(x % gamePkg::GridSize);
        n.y = 4'(y % gamePkg::GridSize);
        return n;
    endfunction

    // expected flags from the body as it stands before the move
    function automatic collisionPkg::hitsT scanHits(input gamePkg::posT p,
                                                    input gamePkg::posT s,
                                                    input gamePkg::posT sh);
        collisionPkg::hitsT h;
        h = '0;
        for (int k = 0; k < NumSegments; k++) begin
            if (mMask[k]) begin
                h.player = h.player | (mSeg[k] == p);
                h.sword  = h.sword | (mSeg[k] == s);
                h.sheep  = h.sheep | (mSeg[k] == sh);
            end
        end
        return h;
    endfunction

    always @(posedge clk) begin
        if (!reset) begin
            mSeg                = {NumSegments{StartHead}};
            mMask               = NumSegments'(1);
            mGrowPend           = 1'b0;
            mFrame              = 1'b0;
            tickCount           = 0;
            sinceFrame          = Idle;
            frameHits           = '0;
            mHitsVis            = '0;
            mTally.lives        = 4'(StartLives);
            mTally.dragonWounds = '0;
            mTally.sheepLost    = '0;
        end else begin
            // scan result lands in the tally on the scanDone cycle
            if (sinceFrame == NumSegments + 1 && mTally.lives != 0) begin
                if (mHitsVis.player) begin
                    mTally.lives = mTally.lives - 1'b1;
                end
                if (mHitsVis.sword && mTally.dragonWounds != 8'hff) begin
                    mTally.dragonWounds = mTally.dragonWounds + 1'b1;
                end
                if (mHitsVis.sheep && mTally.sheepLost != 8'hff) begin
                    mTally.sheepLost = mTally.sheepLost + 1'b1;
                end
            end
            if (mFrame) begin
                frameHits = scanHits(playerPos, swordPos, sheepPos);
                if (grow || mGrowPend) begin
                    mMask = {mMask[NumSegments-2:0], 1'b1};   // lowest free bit
                end
                mGrowPend = 1'b0;
                for (int k = NumSegments - 1; k > 0; k--) begin
                    mSeg[k] = mSeg[k-1];
                end
                mSeg[0]    = stepTile(mSeg[0], dir);
                sinceFrame = 1;     // cycles counted from the frame start cycle
                mHitsVis   = '0;
            end else begin
                if (grow) begin
                    mGrowPend = 1'b1;
                end
                if (sinceFrame < Idle) begin
                    sinceFrame++;
                end
                if (sinceFrame == NumSegments + 1) begin
                    mHitsVis = frameHits;
                end
            end
            mFrame    = (tickCount == FramePeriod - 1);
            tickCount = mFrame ? 0 : tickCount + 1;
        end
    end

    task automatic reportMismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        errorCount++;
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    endtask

    // outputs settle after the rising edge, so checks sample on the falling one
    frameCheck: assert property (@(negedge clk) i_dragonArena.frameStart == mFrame)
        else reportMismatch("frameStart", 64'(mFrame), 64'(i_dragonArena.frameStart));
    scanCheck: assert property (@(negedge clk) scanDone == (sinceFrame == NumSegments + 1))
        else reportMismatch("scanDone", 64'(sinceFrame == NumSegments + 1), 64'(scanDone));
    hitsCheck: assert property (@(negedge clk)
        (sinceFrame == 1 || sinceFrame > NumSegments) |-> hits == mHitsVis)
        else reportMismatch("hits", 64'(mHitsVis), 64'(hits));
    segCheck: assert property (@(negedge clk) segments == mSeg)
        else reportMismatch("segments", 64'(mSeg), 64'(segments));
    maskCheck: assert property (@(negedge clk) activeMask == mMask)
        else reportMismatch("activeMask", 64'(mMask), 64'(activeMask));
    tallyCheck: assert property (@(negedge clk) tally == mTally)
        else reportMismatch("tally", 64'(mTally), 64'(tally));
    overCheck: assert property (@(negedge clk) gameOver == (mTally.lives == 0))
        else reportMismatch("gameOver", 64'(mTally.lives == 0), 64'(gameOver));

    function automatic gamePkg::posT randomTile();
        gamePkg::posT t;
        t.x = 4'($random(seed));
        t.y = 4'($random(seed));
        return t;
    endfunction

    function automatic int randomBelow(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic gamePkg::dirT randomDir();
        return gamePkg::dirT'(2'($random(seed)));
    endfunction

    // tile of the highest inactive segment, or a random one when the mask is full
    function automatic gamePkg::posT inactiveTile();
        gamePkg::posT t;
        t = randomTile();
        for (int k = 0; k < NumSegments; k++) begin
            if (!mMask[k]) begin
                t = mSeg[k];
            end
        end
        return t;
    endfunction

    task automatic placeObjects(input int mode);
        int active;
        active = 0;
        for (int k = 0; k < NumSegments; k++) begin
            active += mMask[k];
        end
        playerPos = randomTile();
        swordPos  = randomTile();
        sheepPos  = randomTile();
        case (mode)
            1: begin
                swordPos = mSeg[randomBelow(active)];
                sheepPos = inactiveTile();
            end
            2: begin
                sheepPos  = mSeg[randomBelow(active)];
                playerPos = inactiveTile();
            end
            3: begin
                playerPos = mSeg[0];          // head is always active
                swordPos  = mSeg[active-1];
            end
            default: ;
        endcase
    endtask

    task automatic waitFrameStart(output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
            ok = i_dragonArena.frameStart;
        end
        if (!ok) begin
            timeoutCount++;
            aborted = 1'b1;
            $display("timeout: no frame start within %0d cycles", WaitLimit);
        end
    endtask

    task automatic waitScanDone(output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
            ok = scanDone;
        end
        if (!ok) begin
            timeoutCount++;
            aborted = 1'b1;
            $display("timeout: scan did not finish within %0d cycles", WaitLimit);
        end
    endtask

    // one frame, with the placement for the next frame made after the scan
    task automatic playFrame(input gamePkg::dirT nextDir, input bit growBetween,
                             input bit growOnStart, input int place, input bit shuffle);
        bit ok;
        waitFrameStart(ok);
        if (!ok) begin
            return;
        end
        grow = growOnStart;     // sampled together with frameStart
        @(negedge clk);
        grow = 1'b0;
        if (shuffle) begin
            repeat (2) @(negedge clk);
            playerPos = randomTile();   // snapshot must hide this
            swordPos  = randomTile();
            sheepPos  = randomTile();
        end
        waitScanDone(ok);
        if (!ok) begin
            return;
        end
        @(negedge clk);
        dir = nextDir;
        placeObjects(place);
        if (growBetween) begin
            grow = 1'b1;
            @(negedge clk);
            grow = 1'b0;
        end
    endtask

    task automatic finishRun();
        $display("errors %0d timeouts %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        int f;
        dir       = gamePkg::dirRight;
        grow      = 1'b0;
        playerPos = '{x: 4'd0, y: 4'd0};
        swordPos  = '{x: 4'd1, y: 4'd0};
        sheepPos  = '{x: 4'd2, y: 4'd0};
        for (f = 0; f < 4 && !aborted; f++) begin
            playFrame(randomDir(), 1'b0, 1'b0, f % 3, 1'b0);
        end
        // long run to the right forces a wrap at the grid edge
        for (f = 0; f < 12 && !aborted; f++) begin
            playFrame(gamePkg::dirRight, 1'b1, 1'b0, f % 3, 1'b0);
        end
        for (f = 0; f < 3 && !aborted; f++) begin
            playFrame(gamePkg::dirDown, 1'b0, 1'b1, 1, 1'b0);   // mask already full
        end
        for (f = 0; f < 8 && !aborted; f++) begin
            playFrame(randomDir(), f % 2, 1'b0, f % 3, 1'b1);
        end
        for (f = 0; f < 6 && !aborted; f++) begin
            playFrame(randomDir(), 1'b0, 1'b0, 3, f % 2);
        end
        if (!aborted && (mTally.lives != 0 || !gameOver)) begin
            errorCount++;
            $display("the game never ended although the player was hit repeatedly");
        end
        repeat (2) @(posedge clk);
        finishRun();
    end

endmodule

// File: all.f
logic/gamePkg.sv
logic/collisionPkg.sv
logic/frameTicker.sv
logic/dragonMover.sv
logic/collisionDetector.sv
logic/gameTally.sv
logic/dragonArena.sv
sim/clockGen.sv
sim/dragonArenaTb.sv

// File: Bender.yml
package:
  name: dragonArena

sources:
  - logic/gamePkg.sv
  - logic/collisionPkg.sv
  - logic/frameTicker.sv
  - logic/dragonMover.sv
  - logic/collisionDetector.sv
  - logic/gameTally.sv
  - logic/dragonArena.sv
  - target: test
    files:
      - sim/clockGen.sv
      - sim/dragonArenaTb.sv
